//--- Makefile
# Verilator build for the execute stage testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_ex_stage
FILELIST  := ex_stage.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ex_stage.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/csr_buffer.sv
rtl/flu_writeback.sv
rtl/ex_stage.sv
verification/ex_stage_assert.sv
verification/tb_ex_stage.sv

//--- rtl/csr_buffer.sv
// ----------------------------------------------------------------------
// Single-entry CSR address buffer, freed on commit or flush
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module csr_buffer import ex_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  csr_valid_i,
    input  logic                  csr_commit_i,
    input  logic [XLEN-1:0]       operand_a_i,
    input  csr_operand_u          operand_b_i,
    output logic [XLEN-1:0]       csr_result_o,
    output logic                  csr_ready_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o
);

    logic                  full_q;
    logic [CSR_ADDR_W-1:0] addr_q;

    // ------------------------------------------------------------------
    // Buffer state
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
            addr_q <= '0;
        end else begin
            if (flush_i || csr_commit_i) begin
                full_q <= 1'b0;
            end else if (csr_valid_i) begin
                full_q <= 1'b1;
            end
            // Address comes from the CSR view of operand b
            if (csr_valid_i) begin
                addr_q <= operand_b_i.csr.addr;
            end
        end
    end

    // The value to write goes straight to the scoreboard
    assign csr_result_o = operand_a_i;

    // Blocks further issue until the instruction commits
    assign csr_ready_o = ~full_q;
    assign csr_addr_o  = addr_q;

endmodule

`default_nettype wire

//--- rtl/ex_alu.sv
// ----------------------------------------------------------------------
// Single-cycle ALU for add/sub, logic ops, shifts and set-less-than
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  logic            alu_valid_i,
    input  fu_op_e          fu_op_i,
    input  logic [XLEN-1:0] operand_a_i,
    input  logic [XLEN-1:0] operand_b_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    // Keep the adder and shifter quiet while other units are issued
    assign op_a = alu_valid_i ? operand_a_i : '0;
    assign op_b = alu_valid_i ? operand_b_i : '0;

    assign shamt = op_b[4:0];

    // Comparison flags
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // ------------------------------------------------------------------
    // Result selection
    // ------------------------------------------------------------------
    always_comb begin
        result_o = '0;
        case (fu_op_i)
            ADD:  result_o = op_a + op_b;
            SUB:  result_o = op_a - op_b;
            AND:  result_o = op_a & op_b;
            OR:   result_o = op_a | op_b;
            XOR:  result_o = op_a ^ op_b;
            SLL:  result_o = op_a << shamt;
            SRL:  result_o = op_a >> shamt;
            SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
            // Zero-extended flag
            SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            default: begin
                // Non-ALU operators leave the result at zero
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ex_mult.sv
// ----------------------------------------------------------------------
// One-cycle pipelined multiplier for MUL, MULH, MULHSU and MULHU
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_mult import ex_pkg::*; #(
    parameter int unsigned TransIdBits = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   mult_valid_i,
    input  fu_op_e                 fu_op_i,
    input  logic [XLEN-1:0]        operand_a_i,
    input  logic [XLEN-1:0]        operand_b_i,
    input  logic [TransIdBits-1:0] trans_id_i,
    output logic [XLEN-1:0]        result_o,
    output logic                   mult_valid_o,
    output logic [TransIdBits-1:0] mult_trans_id_o
);

    logic [XLEN-1:0]        op_a;
    logic [XLEN-1:0]        op_b;
    logic                   sign_a;
    logic                   sign_b;
    logic [2*XLEN-1:0]      op_a_ext;
    logic [2*XLEN-1:0]      op_b_ext;
    logic [2*XLEN-1:0]      product_full;
    logic [2*XLEN-1:0]      product_q;
    logic                   sel_high_q;
    logic                   valid_q;
    logic [TransIdBits-1:0] trans_id_q;

    // Operand silencing
    assign op_a = mult_valid_i ? operand_a_i : '0;
    assign op_b = mult_valid_i ? operand_b_i : '0;

    // Which operands are treated as signed
    assign sign_a = (fu_op_i == MULH) || (fu_op_i == MULHSU);
    assign sign_b = (fu_op_i == MULH);

    // Full-width extension keeps the low 64 product bits exact
    assign op_a_ext = {{XLEN{sign_a & op_a[XLEN-1]}}, op_a};
    assign op_b_ext = {{XLEN{sign_b & op_b[XLEN-1]}}, op_b};

    assign product_full = op_a_ext * op_b_ext;

    // ------------------------------------------------------------------
    // Pipeline register
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            // A flush kills the operation issued this cycle
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        product_q  <= product_full;
        sel_high_q <= (fu_op_i != MUL);
        trans_id_q <= trans_id_i;
    end

    assign result_o        = sel_high_q ? product_q[2*XLEN-1:XLEN] : product_q[XLEN-1:0];
    assign mult_valid_o    = valid_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

`default_nettype wire

//--- rtl/ex_pkg.sv
// ----------------------------------------------------------------------
// Execute stage package with the datapath width, operator encoding and
// the dual view of the second operand word
// ----------------------------------------------------------------------

`default_nettype none

package ex_pkg;

    // Datapath width, fixed for the packed union below
    localparam int unsigned XLEN = 32;

    // CSR address field width
    localparam int unsigned CSR_ADDR_W = 12;

    // ------------------------------------------------------------------
    // Operator encoding shared by all fixed latency units
    // ------------------------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // Multiplier
        MUL,
        MULH,
        MULHSU,
        MULHU,
        // CSR access
        CSR_READ,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } fu_op_e;

    // Operand b is a plain data word for the ALU and multiplier,
    // but carries the CSR address in its low bits for CSR instructions
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [XLEN-CSR_ADDR_W-1:0] unused;
            logic [CSR_ADDR_W-1:0]      addr;
        } csr;
    } csr_operand_u;

endpackage

`default_nettype wire

//--- rtl/ex_stage.sv
// ----------------------------------------------------------------------
// Execute stage fixed latency units: ALU, CSR buffer, multiplier and
// the shared write-back port
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; #(
    parameter int unsigned TransIdBits = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    // Issue port
    input  fu_op_e                 fu_op_i,
    input  logic [XLEN-1:0]        operand_a_i,
    input  csr_operand_u           operand_b_i,
    input  logic [TransIdBits-1:0] trans_id_i,
    input  logic                   alu_valid_i,
    input  logic                   csr_valid_i,
    input  logic                   mult_valid_i,
    input  logic                   csr_commit_i,
    // Scoreboard write-back port
    output logic [XLEN-1:0]        flu_result_o,
    output logic [TransIdBits-1:0] flu_trans_id_o,
    output logic                   flu_valid_o,
    output logic                   flu_ready_o,
    output logic [CSR_ADDR_W-1:0]  csr_addr_o
);

    logic [XLEN-1:0]        operand_b_raw;
    logic [XLEN-1:0]        alu_result;
    logic [XLEN-1:0]        csr_result;
    logic                   csr_ready;
    logic [XLEN-1:0]        mult_result;
    logic [TransIdBits-1:0] mult_trans_id;
    logic                   mult_valid;

    // Data view of operand b for the arithmetic units
    assign operand_b_raw = operand_b_i.raw;

    // ------------------------------------------------------------------
    // Result producers
    // ------------------------------------------------------------------
    ex_alu alu_i (
        .alu_valid_i (alu_valid_i),
        .fu_op_i     (fu_op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_raw),
        .result_o    (alu_result)
    );

    ex_mult #(
        .TransIdBits (TransIdBits)
    ) mult_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .fu_op_i         (fu_op_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_raw),
        .trans_id_i      (trans_id_i),
        .result_o        (mult_result),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id)
    );

    // CSR address holding buffer
    csr_buffer csr_buffer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .csr_result_o (csr_result),
        .csr_ready_o  (csr_ready),
        .csr_addr_o   (csr_addr_o)
    );

    // ------------------------------------------------------------------
    // Write-back
    // ------------------------------------------------------------------
    flu_writeback #(
        .TransIdBits (TransIdBits)
    ) writeback_i (
        .alu_valid_i     (alu_valid_i),
        .csr_valid_i     (csr_valid_i),
        .trans_id_i      (trans_id_i),
        .alu_result_i    (alu_result),
        .csr_result_i    (csr_result),
        .csr_ready_i     (csr_ready),
        .mult_valid_i    (mult_valid),
        .mult_result_i   (mult_result),
        .mult_trans_id_i (mult_trans_id),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o),
        .flu_valid_o     (flu_valid_o),
        .flu_ready_o     (flu_ready_o)
    );

endmodule

`default_nettype wire

//--- rtl/flu_writeback.sv
// ----------------------------------------------------------------------
// Write-back selector for the shared fixed latency scoreboard port
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module flu_writeback import ex_pkg::*; #(
    parameter int unsigned TransIdBits = 3
) (
    input  logic                   alu_valid_i,
    input  logic                   csr_valid_i,
    input  logic [TransIdBits-1:0] trans_id_i,
    input  logic [XLEN-1:0]        alu_result_i,
    input  logic [XLEN-1:0]        csr_result_i,
    input  logic                   csr_ready_i,
    input  logic                   mult_valid_i,
    input  logic [XLEN-1:0]        mult_result_i,
    input  logic [TransIdBits-1:0] mult_trans_id_i,
    output logic [XLEN-1:0]        flu_result_o,
    output logic [TransIdBits-1:0] flu_trans_id_o,
    output logic                   flu_valid_o,
    output logic                   flu_ready_o
);

    // Priority ALU > CSR > multiplier
    always_comb begin
        flu_result_o   = '0;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i) begin
            // Multiplier result belongs to last cycle's issue
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    assign flu_valid_o = alu_valid_i | csr_valid_i | mult_valid_i;

    // Only the CSR buffer can stall issue
    assign flu_ready_o = csr_ready_i;

endmodule

`default_nettype wire

//--- verification/ex_stage_assert.sv
// ----------------------------------------------------------------------
// Concurrent assertions on issue rules and write-back port timing
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ex_stage_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic alu_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic csr_commit_i,
    input logic flu_valid_i,
    input logic flu_ready_i
);

    // At most one unit strobe per cycle
    strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, csr_valid_i, mult_valid_i}))
        else $error("more than one issue strobe high");

    // CSR issue only into an empty buffer
    csr_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> flu_ready_i)
        else $error("CSR issued while buffer full");

    // Multiplier result one cycle later unless killed
    mult_result_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_valid_i && !flush_i) |=> flu_valid_i)
        else $error("multiplier result missing one cycle after issue");

    // Commit frees the buffer
    commit_frees_buffer: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_commit_i |=> flu_ready_i)
        else $error("buffer still full after commit");

endmodule

bind ex_stage ex_stage_assert assert_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .alu_valid_i  (alu_valid_i),
    .csr_valid_i  (csr_valid_i),
    .mult_valid_i (mult_valid_i),
    .csr_commit_i (csr_commit_i),
    .flu_valid_i  (flu_valid_o),
    .flu_ready_i  (flu_ready_o)
);

`default_nettype wire

//--- verification/tb_ex_stage.sv
// ----------------------------------------------------------------------
// Execute stage testbench with seeded random issue, reference model,
// per-cycle write-back checks and timeout
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

    localparam int ID_W           = 3;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = 2 * NUM_CYCLES + RESET_CYCLES;

    logic             clk_i;
    logic             rst_ni;
    logic             flush_i;
    fu_op_e           fu_op_i;
    logic [XLEN-1:0]  operand_a_i;
    csr_operand_u     operand_b_i;
    logic [ID_W-1:0]  trans_id_i;
    logic             alu_valid_i;
    logic             csr_valid_i;
    logic             mult_valid_i;
    logic             csr_commit_i;
    logic [XLEN-1:0]  flu_result_o;
    logic [ID_W-1:0]  flu_trans_id_o;
    logic             flu_valid_o;
    logic             flu_ready_o;
    logic [CSR_ADDR_W-1:0] csr_addr_o;

    integer seed;
    int     error_cnt;
    int     check_cnt;
    int     cycle_cnt;
    int     b2b_cnt;
    int     commit_cnt;
    int     flush_cnt;

    // Model state
    logic                  mult_last;
    logic                  mult_pend;
    logic [XLEN-1:0]       mult_exp_res;
    logic [ID_W-1:0]       mult_exp_id;
    logic                  csr_full;
    logic [CSR_ADDR_W-1:0] csr_exp_addr;

    ex_stage #(
        .TransIdBits (ID_W)
    ) dut_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .fu_op_i        (fu_op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .trans_id_i     (trans_id_i),
        .alu_valid_i    (alu_valid_i),
        .csr_valid_i    (csr_valid_i),
        .mult_valid_i   (mult_valid_i),
        .csr_commit_i   (csr_commit_i),
        .flu_result_o   (flu_result_o),
        .flu_trans_id_o (flu_trans_id_o),
        .flu_valid_o    (flu_valid_o),
        .flu_ready_o    (flu_ready_o),
        .csr_addr_o     (csr_addr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Reference functions
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // Corner values show up often to exercise signs and shifts
    function automatic logic [31:0] random_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    random_operand = 32'h0000_0000;
            3'd1:    random_operand = 32'h8000_0000;
            3'd2:    random_operand = 32'hffff_ffff;
            default: random_operand = next_rand();
        endcase
    endfunction

    function automatic logic [31:0] alu_model(fu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (op)
            ADD:  r = a + b;
            SUB:  r = a + ~b + 32'd1;
            AND:  r = a & b;
            OR:   r = a | b;
            XOR:  r = a ^ b;
            SLL:  r = a << sh;
            SRL:  r = a >> sh;
            // Fill vacated upper bits with the sign
            SRA: begin
                r = a >> sh;
                if (a[31]) begin
                    r = r | ~(32'hffff_ffff >> sh);
                end
            end
            SLT:  r = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            SLTU: r = {31'b0, a < b};
            default: r = 32'h0;
        endcase
        alu_model = r;
    endfunction

    function automatic logic [31:0] mult_model(fu_op_e op, logic [31:0] a, logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      ub;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ub = longint'({32'b0, b});
        case (op)
            MULH:    p = sa * sb;
            MULHSU:  p = sa * ub;
            default: p = {32'b0, a} * {32'b0, b};
        endcase
        mult_model = (op == MUL) ? p[31:0] : p[63:32];
    endfunction

    // ------------------------------------------------------------------
    // Stimulus, checks and model update
    // ------------------------------------------------------------------
    task automatic drive_issue();
        logic [31:0] r;
        logic [2:0]  pick;
        r = next_rand();
        pick = r[2:0];
        alu_valid_i  = 1'b0;
        csr_valid_i  = 1'b0;
        mult_valid_i = 1'b0;
        fu_op_i      = fu_op_e'(5'(r[15:8] % 8'd10));
        operand_a_i  = random_operand();
        operand_b_i.raw = random_operand();
        trans_id_i   = r[ID_W+3-1:3];
        // No ALU or CSR right after a multiply
        if (mult_last) begin
            if (pick < 3'd4) begin
                mult_valid_i = 1'b1;
                b2b_cnt++;
            end
        end else if (pick < 3'd3) begin
            alu_valid_i = 1'b1;
        end else if (pick == 3'd3 && flu_ready_o) begin
            csr_valid_i = 1'b1;
        end else if (pick < 3'd6) begin
            mult_valid_i = 1'b1;
        end
        if (mult_valid_i) begin
            fu_op_i = fu_op_e'(5'd10 + {3'b0, r[17:16]});
        end else if (csr_valid_i) begin
            fu_op_i = fu_op_e'(5'd14 + {3'b0, r[17:16]});
        end
        csr_commit_i = !flu_ready_o && (r[21:20] == 2'b00);
        flush_i      = (r[28:24] == 5'd0);
        mult_last    = mult_valid_i;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[FAIL] %s exp=%h got=%h at cycle %0d", name, exp, got, cycle_cnt);
        end
    endtask

    task automatic check_outputs();
        logic            exp_valid;
        logic [31:0]     exp_res;
        logic [ID_W-1:0] exp_id;
        exp_valid = alu_valid_i | csr_valid_i | mult_pend;
        exp_res   = mult_exp_res;
        exp_id    = mult_exp_id;
        if (alu_valid_i) begin
            exp_res = alu_model(fu_op_i, operand_a_i, operand_b_i.raw);
            exp_id  = trans_id_i;
        end else if (csr_valid_i) begin
            exp_res = operand_a_i;
            exp_id  = trans_id_i;
        end
        check_value("flu_valid_o", 32'(flu_valid_o), 32'(exp_valid));
        if (exp_valid) begin
            check_value("flu_result_o", flu_result_o, exp_res);
            check_value("flu_trans_id_o", 32'(flu_trans_id_o), 32'(exp_id));
        end
        check_value("flu_ready_o", 32'(flu_ready_o), 32'(!csr_full));
        check_value("csr_addr_o", 32'(csr_addr_o), 32'(csr_exp_addr));
    endtask

    task automatic update_model();
        if (mult_valid_i && flush_i) begin
            flush_cnt++;
        end
        mult_pend = mult_valid_i && !flush_i;
        if (mult_pend) begin
            mult_exp_res = mult_model(fu_op_i, operand_a_i, operand_b_i.raw);
            mult_exp_id  = trans_id_i;
        end
        if (csr_commit_i) begin
            commit_cnt++;
        end
        if (flush_i || csr_commit_i) begin
            csr_full = 1'b0;
        end else if (csr_valid_i) begin
            csr_full = 1'b1;
        end
        if (csr_valid_i) begin
            csr_exp_addr = operand_b_i.raw[CSR_ADDR_W-1:0];
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        seed         = 32'ha3321164;
        error_cnt    = 0;
        check_cnt    = 0;
        b2b_cnt      = 0;
        commit_cnt   = 0;
        flush_cnt    = 0;
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        fu_op_i      = ADD;
        operand_a_i  = '0;
        operand_b_i  = '0;
        trans_id_i   = '0;
        alu_valid_i  = 1'b0;
        csr_valid_i  = 1'b0;
        mult_valid_i = 1'b0;
        csr_commit_i = 1'b0;
        mult_last    = 1'b0;
        mult_pend    = 1'b0;
        mult_exp_res = '0;
        mult_exp_id  = '0;
        csr_full     = 1'b0;
        csr_exp_addr = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        #2;
        // State straight out of reset
        check_outputs();
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(negedge clk_i);
            drive_issue();
            #2;
            check_outputs();
            update_model();
        end
        // Stimulus must have reached the pipelined and flush cases
        if (b2b_cnt == 0 || commit_cnt == 0 || flush_cnt == 0) begin
            error_cnt++;
            $display("Stimulus missed back-to-back multiplies, commits or killed multiplies");
        end
        $display("Checks: %0d, errors: %0d, back-to-back mults: %0d, %s%0d, %s%0d",
                 check_cnt, error_cnt, b2b_cnt, "commits: ", commit_cnt,
                 "killed mults: ", flush_cnt);
        if (error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
